/* source/stonyman_cfg.svh */
`ifndef STONYMAN_CFG_SVH
`define STONYMAN_CFG_SVH

// Pixel array size
`define STONYMAN_ROW_RES    112
`define STONYMAN_COL_RES    112

// Field widths
`define STONYMAN_PIXEL_BITS 7
`define STONYMAN_VALUE_BITS 8
`define STONYMAN_PTR_BITS   3

// Register indices inside the imager
`define STONYMAN_REG_COLSEL 0
`define STONYMAN_REG_ROWSEL 1
`define STONYMAN_REG_VSW    2
`define STONYMAN_REG_HSW    3
`define STONYMAN_REG_VREF   4
`define STONYMAN_REG_CONFIG 5
`define STONYMAN_REG_NBIAS  6
`define STONYMAN_REG_AOBIAS 7

`endif

/* source/stonyman_pkg.sv */
`include "stonyman_cfg.svh"

package stonyman_pkg;

    typedef logic [`STONYMAN_VALUE_BITS-1:0] value_t;
    typedef logic [`STONYMAN_PTR_BITS-1:0]   reg_index_t;

    typedef struct packed {
        logic [`STONYMAN_PIXEL_BITS-1:0] row;
        logic [`STONYMAN_PIXEL_BITS-1:0] col;
    } pixel_addr_t;

    // The four pulse lines of the imager
    typedef struct packed {
        logic resp;
        logic incp;
        logic resv;
        logic incv;
    } chip_pins_t;

    // Bias settings, narrow ones zero-extended
    typedef struct packed {
        value_t vsw;
        value_t hsw;
        value_t vref;
        value_t cfg;
        value_t nbias;
        value_t aobias;
    } bias_settings_t;

    typedef enum logic [1:0] {
        PTR_RESET,
        PTR_SELECT,
        VAL_LOAD,
        VAL_GOTO
    } cmd_kind_e;

    // Value kinds read the whole byte, pointer kinds only the index
    typedef union packed {
        value_t value;
        struct packed {
            logic [`STONYMAN_VALUE_BITS-`STONYMAN_PTR_BITS-1:0] pad;
            reg_index_t                                         index;
        } ptr;
    } cmd_operand_u;

    typedef struct packed {
        cmd_kind_e    kind;
        cmd_operand_u operand;
    } prog_cmd_t;

endpackage

/* source/pulse_programmer.sv */
`timescale 1ns/1ps
`include "stonyman_cfg.svh"

module pulse_programmer (
    input  logic                     clk,
    input  logic                     reset,
    input  stonyman_pkg::prog_cmd_t  init_cmd,
    input  logic                     init_valid,
    input  stonyman_pkg::prog_cmd_t  scan_cmd,
    input  logic                     scan_valid,
    output logic                     init_ready,
    output logic                     scan_ready,
    output stonyman_pkg::chip_pins_t pins
);
    import stonyman_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECIDE,
        ST_HIGH
    } state_e;

    state_e     state;
    logic       grant_init;
    logic       reset_done;
    reg_index_t shadow_ptr;
    value_t     shadow_val [1 << `STONYMAN_PTR_BITS];
    prog_cmd_t  cmd;
    value_t     cur_val;
    chip_pins_t pulse;
    logic       done;

    assign cmd     = grant_init ? init_cmd : scan_cmd;
    assign cur_val = shadow_val[shadow_ptr];

    //////////////////////////////
    // Step selection
    //////////////////////////////

    // Pick the single pulse that moves the shadow closer to the target
    always_comb begin
        pulse = '0;
        done  = 1'b0;
        case (cmd.kind)
            PTR_RESET: begin
                if (!reset_done) pulse.resp = 1'b1;
                else done = 1'b1;
            end
            PTR_SELECT: begin
                if (shadow_ptr < cmd.operand.ptr.index) pulse.incp = 1'b1;
                else if (shadow_ptr > cmd.operand.ptr.index) pulse.resp = 1'b1;
                else done = 1'b1;
            end
            VAL_LOAD: begin
                if (!reset_done) pulse.resv = 1'b1;
                else if (cur_val < cmd.operand.value) pulse.incv = 1'b1;
                else done = 1'b1;
            end
            default: begin
                // Only reset when counting up cannot reach the target
                if (cur_val < cmd.operand.value) pulse.incv = 1'b1;
                else if (cur_val > cmd.operand.value) pulse.resv = 1'b1;
                else done = 1'b1;
            end
        endcase
    end

    assign init_ready = (state == ST_DECIDE) && done && grant_init;
    assign scan_ready = (state == ST_DECIDE) && done && !grant_init;

    //////////////////////////////
    // Pulse timing and shadow
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            grant_init <= 1'b0;
            reset_done <= 1'b0;
            pins       <= '0;
            shadow_ptr <= '0;
            for (int i = 0; i < (1 << `STONYMAN_PTR_BITS); i++) begin
                shadow_val[i] <= '0;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    // Init peer has priority
                    if (init_valid || scan_valid) begin
                        grant_init <= init_valid;
                        reset_done <= 1'b0;
                        state      <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end else begin
                        pins  <= pulse;
                        state <= ST_HIGH;
                    end
                end
                ST_HIGH: begin
                    // Pulse ends here, so the chip has now moved
                    pins <= '0;
                    if (pins.resp) shadow_ptr <= '0;
                    if (pins.incp) shadow_ptr <= shadow_ptr + 1'b1;
                    if (pins.resv) shadow_val[shadow_ptr] <= '0;
                    if (pins.incv) shadow_val[shadow_ptr] <= cur_val + 1'b1;
                    if (pins.resp || pins.resv) reset_done <= 1'b1;
                    state <= ST_DECIDE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/init_sequencer.sv */
`timescale 1ns/1ps
`include "stonyman_cfg.svh"

module init_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  stonyman_pkg::bias_settings_t settings,
    input  logic                         init_ready,
    output stonyman_pkg::prog_cmd_t      init_cmd,
    output logic                         init_valid,
    output logic                         init_done
);
    import stonyman_pkg::*;

    // Pointer reset, then a select and load pair per register
    localparam int NUM_STEPS = 17;

    logic [4:0] step;
    logic [2:0] pair;
    reg_index_t sel_index;
    value_t     load_value;

    assign pair = 3'((step - 5'd1) >> 1);

    // Register order of the power-up sequence
    always_comb begin
        case (pair)
            3'd0: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_COLSEL);
                load_value = '0;
            end
            3'd1: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_ROWSEL);
                load_value = '0;
            end
            3'd2: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_VSW);
                load_value = settings.vsw;
            end
            3'd3: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_HSW);
                load_value = settings.hsw;
            end
            3'd4: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_VREF);
                load_value = settings.vref;
            end
            3'd5: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_NBIAS);
                load_value = settings.nbias;
            end
            3'd6: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_AOBIAS);
                load_value = settings.aobias;
            end
            default: begin
                sel_index  = `STONYMAN_PTR_BITS'(`STONYMAN_REG_CONFIG);
                load_value = settings.cfg;
            end
        endcase
    end

    always_comb begin
        init_cmd = '0;
        if (step == 5'd0) begin
            init_cmd.kind = PTR_RESET;
        end else if (step[0]) begin
            init_cmd.kind                = PTR_SELECT;
            init_cmd.operand.ptr.index   = sel_index;
        end else begin
            init_cmd.kind          = VAL_LOAD;
            init_cmd.operand.value = load_value;
        end
    end

    assign init_valid = !init_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step      <= '0;
            init_done <= 1'b0;
        end else if (init_ready) begin
            step <= step + 5'd1;
            if (step == 5'(NUM_STEPS - 1)) init_done <= 1'b1;
        end
    end

endmodule

/* source/frame_scanner.sv */
`timescale 1ns/1ps
`include "stonyman_cfg.svh"

module frame_scanner (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      init_done,
    input  logic                      frame_capture_start,
    input  logic                      mask_capture_pixel,
    input  logic                      adc_capture_done,
    input  logic                      scan_ready,
    output stonyman_pkg::prog_cmd_t   scan_cmd,
    output logic                      scan_valid,
    output stonyman_pkg::pixel_addr_t mask_addr,
    output logic                      adc_capture_start,
    output logic                      frame_capture_done,
    output logic                      controller_busy
);
    import stonyman_pkg::*;

    localparam logic [`STONYMAN_PIXEL_BITS-1:0] LAST_ROW =
        `STONYMAN_PIXEL_BITS'(`STONYMAN_ROW_RES - 1);
    localparam logic [`STONYMAN_PIXEL_BITS-1:0] LAST_COL =
        `STONYMAN_PIXEL_BITS'(`STONYMAN_COL_RES - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ROW_PTR,
        ST_ROW_VAL,
        ST_COL_PTR,
        ST_COL_VAL,
        ST_MASK,
        ST_ADC_WAIT
    } state_e;

    state_e state;
    logic   advance;

    // Pixel finished, skipped by the mask or read by the ADC
    assign advance = ((state == ST_MASK) && !mask_capture_pixel) ||
                     ((state == ST_ADC_WAIT) && adc_capture_done);

    assign controller_busy = !init_done || (state != ST_IDLE);

    always_comb begin
        scan_cmd   = '0;
        scan_valid = 1'b1;
        case (state)
            ST_ROW_PTR: begin
                scan_cmd.kind              = PTR_SELECT;
                scan_cmd.operand.ptr.index = `STONYMAN_PTR_BITS'(`STONYMAN_REG_ROWSEL);
            end
            ST_ROW_VAL: begin
                scan_cmd.kind          = VAL_GOTO;
                scan_cmd.operand.value = value_t'(mask_addr.row);
            end
            ST_COL_PTR: begin
                scan_cmd.kind              = PTR_SELECT;
                scan_cmd.operand.ptr.index = `STONYMAN_PTR_BITS'(`STONYMAN_REG_COLSEL);
            end
            ST_COL_VAL: begin
                scan_cmd.kind          = VAL_GOTO;
                scan_cmd.operand.value = value_t'(mask_addr.col);
            end
            default: scan_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state              <= ST_IDLE;
            mask_addr          <= '0;
            adc_capture_start  <= 1'b0;
            frame_capture_done <= 1'b0;
        end else begin
            adc_capture_start  <= 1'b0;
            frame_capture_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (frame_capture_start && init_done) begin
                        mask_addr <= '0;
                        state     <= ST_ROW_PTR;
                    end
                end
                ST_ROW_PTR: if (scan_ready) state <= ST_ROW_VAL;
                ST_ROW_VAL: if (scan_ready) state <= ST_COL_PTR;
                ST_COL_PTR: if (scan_ready) state <= ST_COL_VAL;
                ST_COL_VAL: if (scan_ready) state <= ST_MASK;
                ST_MASK: begin
                    if (mask_capture_pixel) begin
                        adc_capture_start <= 1'b1;
                        state             <= ST_ADC_WAIT;
                    end
                end
                // Held here until the ADC reports done
                ST_ADC_WAIT: state <= ST_ADC_WAIT;
                default: state <= ST_IDLE;
            endcase

            //////////////////////////////
            // Next pixel
            //////////////////////////////
            if (advance) begin
                if (mask_addr.col != LAST_COL) begin
                    // Same row, only the column moves
                    mask_addr.col <= mask_addr.col + 1'b1;
                    state         <= ST_COL_VAL;
                end else if (mask_addr.row != LAST_ROW) begin
                    mask_addr.row <= mask_addr.row + 1'b1;
                    mask_addr.col <= '0;
                    state         <= ST_ROW_PTR;
                end else begin
                    mask_addr          <= '0;
                    frame_capture_done <= 1'b1;
                    state              <= ST_IDLE;
                end
            end
        end
    end

endmodule

/* source/stonyman_controller.sv */
`timescale 1ns/1ps

module stonyman_controller (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         frame_capture_start,
    input  logic                         adc_capture_done,
    input  logic                         mask_capture_pixel,
    input  stonyman_pkg::bias_settings_t settings,
    output logic                         controller_busy,
    output logic                         frame_capture_done,
    output logic                         adc_capture_start,
    output stonyman_pkg::chip_pins_t     pins,
    output stonyman_pkg::pixel_addr_t    mask_addr
);
    import stonyman_pkg::*;

    // Command channels into the shared programmer
    prog_cmd_t init_cmd;
    logic      init_valid;
    logic      init_ready;
    prog_cmd_t scan_cmd;
    logic      scan_valid;
    logic      scan_ready;
    logic      init_done;

    pulse_programmer programmer_i (
        .clk        (clk),
        .reset      (reset),
        .init_cmd   (init_cmd),
        .init_valid (init_valid),
        .scan_cmd   (scan_cmd),
        .scan_valid (scan_valid),
        .init_ready (init_ready),
        .scan_ready (scan_ready),
        .pins       (pins)
    );

    init_sequencer init_i (
        .clk        (clk),
        .reset      (reset),
        .settings   (settings),
        .init_ready (init_ready),
        .init_cmd   (init_cmd),
        .init_valid (init_valid),
        .init_done  (init_done)
    );

    frame_scanner scanner_i (
        .clk                 (clk),
        .reset               (reset),
        .init_done           (init_done),
        .frame_capture_start (frame_capture_start),
        .mask_capture_pixel  (mask_capture_pixel),
        .adc_capture_done    (adc_capture_done),
        .scan_ready          (scan_ready),
        .scan_cmd            (scan_cmd),
        .scan_valid          (scan_valid),
        .mask_addr           (mask_addr),
        .adc_capture_start   (adc_capture_start),
        .frame_capture_done  (frame_capture_done),
        .controller_busy     (controller_busy)
    );

endmodule

/* sim/stonyman_chk.sv */
`timescale 1ns/1ps

module stonyman_chk (
    input logic                     clk,
    input logic                     reset,
    input stonyman_pkg::chip_pins_t pins,
    input logic                     adc_capture_start,
    input logic                     frame_capture_done,
    input logic                     controller_busy
);
    logic [3:0] pin_bits;
    int         fail_count = 0;

    assign pin_bits = pins;

    //////////////////////////////
    // Pin pulse shape
    //////////////////////////////

    one_pin_high: assert property (@(posedge clk) disable iff (reset) $onehot0(pin_bits))
        else begin
            $error("more than one imager pin high at once");
            fail_count++;
        end

    // Every pulse is followed by a low cycle
    pulse_gap: assert property (@(posedge clk) disable iff (reset)
        (pin_bits != 4'b0) |=> (pin_bits == 4'b0))
        else begin
            $error("imager pin high for two cycles in a row");
            fail_count++;
        end

    //////////////////////////////
    // Status outputs
    //////////////////////////////

    adc_while_busy: assert property (@(posedge clk) disable iff (reset)
        adc_capture_start |-> controller_busy)
        else begin
            $error("adc_capture_start while the controller is idle");
            fail_count++;
        end

    done_single: assert property (@(posedge clk) disable iff (reset)
        frame_capture_done |=> !frame_capture_done)
        else begin
            $error("frame_capture_done longer than one cycle");
            fail_count++;
        end

endmodule

bind stonyman_controller stonyman_chk chk_i (
    .clk                (clk),
    .reset              (reset),
    .pins               (pins),
    .adc_capture_start  (adc_capture_start),
    .frame_capture_done (frame_capture_done),
    .controller_busy    (controller_busy)
);

/* sim/stonyman_tb.sv */
`timescale 1ns/1ps
`include "stonyman_cfg.svh"

module stonyman_tb;
    import stonyman_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int INIT_TIMEOUT  = 20000;
    localparam int FRAME_TIMEOUT = 2000000;
    localparam int QUIET_CYCLES  = 64;
    localparam int PIXEL_COUNT   = `STONYMAN_ROW_RES * `STONYMAN_COL_RES;
    localparam reg_index_t COL_REG = reg_index_t'(`STONYMAN_REG_COLSEL);
    localparam reg_index_t ROW_REG = reg_index_t'(`STONYMAN_REG_ROWSEL);

    logic           clk;
    logic           reset;
    logic           frame_capture_start;
    logic           adc_capture_done;
    logic           mask_capture_pixel;
    bias_settings_t settings;
    logic           controller_busy;
    logic           frame_capture_done;
    logic           adc_capture_start;
    chip_pins_t     pins;
    pixel_addr_t    mask_addr;

    integer     seed;
    int         pattern;
    int         adc_starts = 0;
    int         done_count = 0;
    // Next raster position the scanner may capture in the current frame
    int         scan_pos = 0;
    reg_index_t model_ptr;
    value_t     model_val [1 << `STONYMAN_PTR_BITS];

    stonyman_controller dut_i (
        .clk                 (clk),
        .reset               (reset),
        .frame_capture_start (frame_capture_start),
        .adc_capture_done    (adc_capture_done),
        .mask_capture_pixel  (mask_capture_pixel),
        .settings            (settings),
        .controller_busy     (controller_busy),
        .frame_capture_done  (frame_capture_done),
        .adc_capture_start   (adc_capture_start),
        .pins                (pins),
        .mask_addr           (mask_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Reference and checks
    //////////////////////////////

    // Pattern 1 selects every third pixel in raster order and pattern 2 a checkerboard
    function automatic logic mask_of(input pixel_addr_t addr, input int pat);
        int raster;
        raster = int'(addr.row) * `STONYMAN_COL_RES + int'(addr.col);
        case (pat)
            1: return (raster % 3) == 0;
            2: return addr.row[0] == addr.col[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic int count_of(input int pat);
        pixel_addr_t addr;
        int          total;
        total = 0;
        for (int r = 0; r < `STONYMAN_ROW_RES; r++) begin
            for (int c = 0; c < `STONYMAN_COL_RES; c++) begin
                addr.row = `STONYMAN_PIXEL_BITS'(r);
                addr.col = `STONYMAN_PIXEL_BITS'(c);
                if (mask_of(addr, pat)) total++;
            end
        end
        return total;
    endfunction

    // Raster position back to a row and column
    function automatic pixel_addr_t pixel_at(input int raster);
        pixel_addr_t addr;
        addr.row = `STONYMAN_PIXEL_BITS'(raster / `STONYMAN_COL_RES);
        addr.col = `STONYMAN_PIXEL_BITS'(raster % `STONYMAN_COL_RES);
        return addr;
    endfunction

    // First selected raster position at or after the given one
    function automatic int next_capture(input int from, input int pat);
        int pos;
        pos = from;
        while (pos < PIXEL_COUNT && !mask_of(pixel_at(pos), pat)) begin
            pos++;
        end
        return pos;
    endfunction

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input value_t actual, input value_t expected);
        if (actual !== expected) begin
            fail_now($sformatf("mismatch %s: got 0x%02h, expected 0x%02h",
                               name, actual, expected));
        end
    endtask

    task automatic check_pixel(input string name, input pixel_addr_t actual,
                               input pixel_addr_t expected);
        if (actual !== expected) begin
            fail_now($sformatf(
                "mismatch %s: got row 0x%02h col 0x%02h, expected row 0x%02h col 0x%02h",
                name, actual.row, actual.col, expected.row, expected.col));
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual !== expected) begin
            fail_now($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    task automatic check_bias();
        check_value("register vsw", model_val[reg_index_t'(`STONYMAN_REG_VSW)], settings.vsw);
        check_value("register hsw", model_val[reg_index_t'(`STONYMAN_REG_HSW)], settings.hsw);
        check_value("register vref", model_val[reg_index_t'(`STONYMAN_REG_VREF)], settings.vref);
        check_value("register config", model_val[reg_index_t'(`STONYMAN_REG_CONFIG)],
                    settings.cfg);
        check_value("register nbias", model_val[reg_index_t'(`STONYMAN_REG_NBIAS)],
                    settings.nbias);
        check_value("register aobias", model_val[reg_index_t'(`STONYMAN_REG_AOBIAS)],
                    settings.aobias);
    endtask

    // Imager model that counts the pulses on each line
    initial begin
        model_ptr = 3'd6;
        for (int i = 0; i < (1 << `STONYMAN_PTR_BITS); i++) begin
            model_val[reg_index_t'(i)] = value_t'(8'h5a + i * 37);
        end
        forever begin
            @(posedge clk);
            if (pins.resp) model_ptr <= '0;
            if (pins.incp) model_ptr <= model_ptr + 1'b1;
            if (pins.resv) model_val[model_ptr] <= '0;
            if (pins.incv) model_val[model_ptr] <= model_val[model_ptr] + 1'b1;
        end
    end

    initial begin
        mask_capture_pixel = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            mask_capture_pixel = mask_of(mask_addr, pattern);
        end
    end

    // ADC answers each start after 1 to 20 cycles
    initial begin
        int delay;
        adc_capture_done = 1'b0;
        forever begin
            @(negedge clk);
            if (adc_capture_start) begin
                delay = 1 + int'($unsigned($random(seed)) % 20);
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                adc_capture_done = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                adc_capture_done = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        pixel_addr_t expected_addr;
        if (!reset) begin
            if (dut_i.chk_i.fail_count != 0) begin
                fail_now("a bound assertion on the controller failed");
            end
            if (adc_capture_start) begin
                adc_starts++;
                scan_pos = next_capture(scan_pos, pattern);
                if (scan_pos >= PIXEL_COUNT) begin
                    fail_now("ADC capture started after the last selected pixel");
                end
                expected_addr = pixel_at(scan_pos);
                scan_pos++;
                check_pixel("mask_addr", mask_addr, expected_addr);
                check_value("model row register", model_val[ROW_REG],
                            value_t'(expected_addr.row));
                check_value("model column register", model_val[COL_REG],
                            value_t'(expected_addr.col));
                check_value("model pointer", value_t'(model_ptr), value_t'(COL_REG));
            end
            if (frame_capture_done) begin
                done_count++;
                check_count("controller_busy at frame done", int'(controller_busy), 0);
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic wait_for_idle(input int limit, input string what);
        int n;
        n = 0;
        while (controller_busy) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("timeout: controller still busy during %s", what));
            end
        end
    endtask

    task automatic pulse_frame_start();
        @(posedge clk);
        #DRIVE_DELAY;
        frame_capture_start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        frame_capture_start = 1'b0;
    endtask

    task automatic run_frame(input int pat);
        int starts_before;
        int done_before;
        int expected;
        int n;
        pattern = pat;
        scan_pos = 0;
        expected = count_of(pat);
        starts_before = adc_starts;
        done_before = done_count;
        pulse_frame_start();
        @(negedge clk);
        check_count("controller_busy after frame start", int'(controller_busy), 1);
        // A request while busy must be ignored
        repeat (4) @(posedge clk);
        pulse_frame_start();
        n = 0;
        while (done_count == done_before) begin
            @(posedge clk);
            n++;
            if (n > FRAME_TIMEOUT) fail_now("timeout: frame_capture_done never came");
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_count("controller_busy after frame", int'(controller_busy), 0);
        check_count("frame_capture_done pulses", done_count - done_before, 1);
        check_count("adc_capture_start pulses", adc_starts - starts_before, expected);
    endtask

    initial begin
        seed = 32'hb500_da62;
        pattern = 0;
        reset = 1'b1;
        frame_capture_start = 1'b0;
        settings.vsw    = value_t'($random(seed) & 32'h3f);
        settings.hsw    = value_t'($random(seed) & 32'h3f);
        settings.vref   = value_t'($random(seed));
        settings.cfg    = value_t'($random(seed));
        settings.nbias  = value_t'($random(seed) & 32'h3f);
        settings.aobias = value_t'($random(seed) & 32'h3f);

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_count("controller_busy in reset", int'(controller_busy), 1);
        check_count("pins in reset", int'(pins), 0);
        check_count("adc_capture_start in reset", int'(adc_capture_start), 0);
        check_count("frame_capture_done in reset", int'(frame_capture_done), 0);
        @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        wait_for_idle(INIT_TIMEOUT, "initialization");
        check_value("register colsel", model_val[COL_REG], '0);
        check_value("register rowsel", model_val[ROW_REG], '0);
        check_bias();

        run_frame(1);
        run_frame(2);
        check_bias();

        if (dut_i.chk_i.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_now("bound assertions failed during the run");
        end
    end

endmodule

/* sources.f */
+incdir+source
source/stonyman_pkg.sv
source/pulse_programmer.sv
source/init_sequencer.sv
source/frame_scanner.sv
source/stonyman_controller.sv
sim/stonyman_chk.sv
sim/stonyman_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= stonyman_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard source/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
